/* Makefile */
# Verilator simulation of the hybrid decimator
# Any variable can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= hybridDecimTb
FILELIST  ?= hybridDecim.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# Build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* design/decim_cfg.svh */
`ifndef DECIM_CFG_SVH
`define DECIM_CFG_SVH

// Modulator code width, read as signed -2..1
`define DECIM_SAMPLE_W 2

// Codes per frame, also the decimation factor
`define DECIM_RATIO 8

// FIR length, a whole number of frames
`define DECIM_TAPS 16

// Unsigned coefficient width
`define DECIM_COEF_W 6

// Signed FIR sum width
`define DECIM_FIR_W 10

// Signed recursion accumulator width
`define DECIM_ACC_W 16

// Leak of the recursion as a right shift
`define DECIM_LEAK_SHIFT 3

// Offset-binary output word width
`define DECIM_OUT_W 14

// Input buffer depth and starting source credits
`define DECIM_IN_CREDITS 4

// Result FIFO depth
`define DECIM_OUT_DEPTH 4

`endif

/* design/filterPkg.sv */
`include "decim_cfg.svh"

package filterPkg;

    // One modulator code
    typedef logic signed [`DECIM_SAMPLE_W-1:0] codeT;

    // FIR coefficient, always positive
    typedef logic [`DECIM_COEF_W-1:0] coefT;

    // Lookahead FIR result
    typedef logic signed [`DECIM_FIR_W-1:0] firSumT;

    // Lookback accumulator
    typedef logic signed [`DECIM_ACC_W-1:0] accValueT;

    // First frame only loads history
    typedef enum logic {
        stWarm,
        stRun
    } stageStateT;

    // Triangular window, tap 0 is the newest code
    function automatic coefT coefTap(input int k);
        int weight;
        if (k < `DECIM_RATIO) begin
            weight = k + 1;
        end else begin
            weight = `DECIM_TAPS - k;
        end
        return coefT'(weight);
    endfunction

    // Signed product of one code with its tap weight
    function automatic firSumT tapProduct(input codeT code, input int k);
        firSumT coefExt;
        firSumT codeExt;
        coefExt = firSumT'({1'b0, coefTap(k)});
        codeExt = firSumT'(code);
        return coefExt * codeExt;
    endfunction

endpackage

/* design/frameCollector.sv */
`timescale 1ns/1ps
`include "decim_cfg.svh"

module frameCollector
    import streamPkg::*, filterPkg::*;
(
    input  logic       clkDS,
    input  logic       rstN,
    input  sampleBeatT inBeat,
    output logic       inCredit,
    output frameWordT  frame,
    input  logic       frameCredit
);

    localparam int depth = `DECIM_IN_CREDITS;
    localparam int ptrW = $clog2(depth);
    localparam int posW = $clog2(`DECIM_RATIO);

    codeT            fifoMem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [ptrW:0]   fifoCount;

    frameCodesT      frameCodes;
    logic [posW-1:0] codePos;
    logic            frameFull;
    logic            firCredit;

    logic push;
    logic pop;
    logic sendFrame;

    assign push = inBeat.valid;
    assign sendFrame = frameFull && firCredit;
    // Drain stalls while a finished frame waits for credit
    assign pop = (fifoCount != '0) && (!frameFull || sendFrame);
    assign inCredit = pop;

    assign frame.valid = sendFrame;
    assign frame.codes = frameCodes;

    always_ff @(posedge clkDS) begin
        if (push) begin
            fifoMem[wrPtr] <= inBeat.code;
        end
        if (pop) begin
            frameCodes[codePos] <= fifoMem[rdPtr];
        end
    end

    always_ff @(posedge clkDS or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fifoCount <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10: fifoCount <= fifoCount + 1'b1;
                2'b01: fifoCount <= fifoCount - 1'b1;
                default: fifoCount <= fifoCount;
            endcase
        end
    end

    // Frame assembly and the single credit toward the FIR
    always_ff @(posedge clkDS or negedge rstN) begin
        if (!rstN) begin
            codePos <= '0;
            frameFull <= 1'b0;
            firCredit <= 1'b1;
        end else begin
            if (pop) begin
                codePos <= (codePos == posW'(`DECIM_RATIO - 1)) ? '0 : codePos + 1'b1;
            end
            if (pop && codePos == posW'(`DECIM_RATIO - 1)) begin
                frameFull <= 1'b1;
            end else if (sendFrame) begin
                frameFull <= 1'b0;
            end
            if (sendFrame && !frameCredit) begin
                firCredit <= 1'b0;
            end else if (!sendFrame && frameCredit) begin
                firCredit <= 1'b1;
            end
        end
    end

endmodule

/* design/hybridDecim.sv */
`timescale 1ns/1ps

module hybridDecim
    import streamPkg::*;
#(
    parameter int sinkCredits = 2
) (
    input  logic       clkDS,
    input  logic       rstN,
    input  sampleBeatT inBeat,
    output logic       inCredit,
    output resultWordT outWord,
    input  logic       outCredit
);

    frameWordT frame;
    logic      frameCredit;
    firWordT   fir;
    accWordT   acc;
    logic      slotCredit;

    frameCollector u_frameCollector (
        .clkDS       (clkDS),
        .rstN        (rstN),
        .inBeat      (inBeat),
        .inCredit    (inCredit),
        .frame       (frame),
        .frameCredit (frameCredit)
    );

    // Slot credits skip the recursion and return straight to the FIR
    lookaheadFir u_lookaheadFir (
        .clkDS       (clkDS),
        .rstN        (rstN),
        .frame       (frame),
        .frameCredit (frameCredit),
        .slotCredit  (slotCredit),
        .fir         (fir)
    );

    lookbackRecursion u_lookbackRecursion (
        .clkDS (clkDS),
        .rstN  (rstN),
        .fir   (fir),
        .acc   (acc)
    );

    resultQueue #(
        .sinkCredits (sinkCredits)
    ) u_resultQueue (
        .clkDS      (clkDS),
        .rstN       (rstN),
        .acc        (acc),
        .slotCredit (slotCredit),
        .outWord    (outWord),
        .outCredit  (outCredit)
    );

endmodule

/* design/lookaheadFir.sv */
`timescale 1ns/1ps
`include "decim_cfg.svh"

module lookaheadFir
    import streamPkg::*, filterPkg::*;
(
    input  logic      clkDS,
    input  logic      rstN,
    input  frameWordT frame,
    output logic      frameCredit,
    input  logic      slotCredit,
    output firWordT   fir
);

    localparam int groupSize = 4;
    localparam int numGroups = `DECIM_TAPS / groupSize;
    localparam int slotW = $clog2(`DECIM_OUT_DEPTH + 1);

    stageStateT       state;
    logic [slotW-1:0] slotCount;

    frameCodesT pendCodes;
    logic       pendValid;
    frameCodesT histCodes;
    logic       accept;
    logic       runAccept;

    codeT   window [`DECIM_TAPS];
    firSumT groupSum [numGroups];
    firSumT partialSum [numGroups];
    logic   partialValid;
    firSumT totalSum;
    firSumT firSum;
    logic   firValid;

    // Warm-up frame needs no result slot
    assign accept = pendValid && (state == stWarm || slotCount != '0);
    assign runAccept = accept && (state == stRun);

    // Tap 0 is the newest code of the current frame
    always_comb begin
        for (int k = 0; k < `DECIM_RATIO; k++) begin
            window[k] = pendCodes[`DECIM_RATIO - 1 - k];
            window[k + `DECIM_RATIO] = histCodes[`DECIM_RATIO - 1 - k];
        end
    end

    always_comb begin
        for (int g = 0; g < numGroups; g++) begin
            groupSum[g] = '0;
            for (int i = 0; i < groupSize; i++) begin
                groupSum[g] = groupSum[g]
                    + tapProduct(window[g * groupSize + i], g * groupSize + i);
            end
        end
    end

    always_comb begin
        totalSum = '0;
        for (int g = 0; g < numGroups; g++) begin
            totalSum = totalSum + partialSum[g];
        end
    end

    // Payload path: holding register, history, two pipeline stages
    always_ff @(posedge clkDS) begin
        if (frame.valid) begin
            pendCodes <= frame.codes;
        end
        if (accept) begin
            histCodes <= pendCodes;
        end
        if (runAccept) begin
            partialSum <= groupSum;
        end
        if (partialValid) begin
            firSum <= totalSum;
        end
    end

    always_ff @(posedge clkDS or negedge rstN) begin
        if (!rstN) begin
            state <= stWarm;
            pendValid <= 1'b0;
            frameCredit <= 1'b0;
            slotCount <= slotW'(`DECIM_OUT_DEPTH);
            partialValid <= 1'b0;
            firValid <= 1'b0;
        end else begin
            if (frame.valid) begin
                pendValid <= 1'b1;
            end else if (accept) begin
                pendValid <= 1'b0;
            end
            frameCredit <= accept;
            if (accept) begin
                state <= stRun;
            end
            case ({runAccept, slotCredit})
                2'b10: slotCount <= slotCount - 1'b1;
                2'b01: slotCount <= slotCount + 1'b1;
                default: slotCount <= slotCount;
            endcase
            partialValid <= runAccept;
            firValid <= partialValid;
        end
    end

    assign fir.valid = firValid;
    assign fir.sum = firSum;

endmodule

/* design/lookbackRecursion.sv */
`timescale 1ns/1ps
`include "decim_cfg.svh"

module lookbackRecursion
    import streamPkg::*, filterPkg::*;
(
    input  logic    clkDS,
    input  logic    rstN,
    input  firWordT fir,
    output accWordT acc
);

    accValueT accReg;
    logic     accValid;
    accValueT firExt;
    accValueT leakTerm;
    accValueT nextAcc;

    // Sign-extend the FIR sum to accumulator width
    assign firExt = accValueT'(fir.sum);

    // Arithmetic shift keeps the leak sign-correct
    assign leakTerm = accReg >>> `DECIM_LEAK_SHIFT;

    assign nextAcc = accReg + firExt - leakTerm;

    // One update per FIR result, otherwise hold
    always_ff @(posedge clkDS or negedge rstN) begin
        if (!rstN) begin
            accReg <= '0;
            accValid <= 1'b0;
        end else begin
            accValid <= fir.valid;
            if (fir.valid) begin
                accReg <= nextAcc;
            end
        end
    end

    // The register holds the freshly updated value
    assign acc.valid = accValid;
    assign acc.value = accReg;

endmodule

/* design/resultQueue.sv */
`timescale 1ns/1ps
`include "decim_cfg.svh"

module resultQueue
    import streamPkg::*, filterPkg::*;
#(
    parameter int sinkCredits = 2
) (
    input  logic       clkDS,
    input  logic       rstN,
    input  accWordT    acc,
    output logic       slotCredit,
    output resultWordT outWord,
    input  logic       outCredit
);

    localparam int depth = `DECIM_OUT_DEPTH;
    localparam int ptrW = $clog2(depth);
    localparam int sinkW = $clog2(sinkCredits + 1);
    localparam accValueT outMax = accValueT'(2 ** (`DECIM_OUT_W - 1) - 1);
    localparam accValueT outMin = accValueT'(-(2 ** (`DECIM_OUT_W - 1)));

    logic signed [`DECIM_OUT_W-1:0] satValue;
    logic [`DECIM_OUT_W-1:0]        offsetWord;

    logic [`DECIM_OUT_W-1:0] fifoMem [depth];
    logic [ptrW-1:0]         wrPtr;
    logic [ptrW-1:0]         rdPtr;
    logic [ptrW:0]           fifoCount;
    logic [sinkW-1:0]        sinkCount;

    logic push;
    logic pop;

    // Clamp to the signed output range
    always_comb begin
        if (acc.value > outMax) begin
            satValue = outMax[`DECIM_OUT_W-1:0];
        end else if (acc.value < outMin) begin
            satValue = outMin[`DECIM_OUT_W-1:0];
        end else begin
            satValue = acc.value[`DECIM_OUT_W-1:0];
        end
    end

    // Offset binary: flip the sign bit
    assign offsetWord = {~satValue[`DECIM_OUT_W-1], satValue[`DECIM_OUT_W-2:0]};

    assign push = acc.valid;
    assign pop = (fifoCount != '0) && (sinkCount != '0);

    assign outWord.valid = pop;
    assign outWord.data = fifoMem[rdPtr];
    // Freed slot goes back to the FIR
    assign slotCredit = pop;

    always_ff @(posedge clkDS) begin
        if (push) begin
            fifoMem[wrPtr] <= offsetWord;
        end
    end

    always_ff @(posedge clkDS or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fifoCount <= '0;
            sinkCount <= sinkW'(sinkCredits);
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10: fifoCount <= fifoCount + 1'b1;
                2'b01: fifoCount <= fifoCount - 1'b1;
                default: fifoCount <= fifoCount;
            endcase
            case ({pop, outCredit})
                2'b10: sinkCount <= sinkCount - 1'b1;
                2'b01: sinkCount <= sinkCount + 1'b1;
                default: sinkCount <= sinkCount;
            endcase
        end
    end

endmodule

/* design/streamPkg.sv */
`include "decim_cfg.svh"

package streamPkg;
    import filterPkg::*;

    // Oldest code at index 0
    typedef codeT [`DECIM_RATIO-1:0] frameCodesT;

    // Source to input side
    typedef struct packed {
        logic valid;
        codeT code;
    } sampleBeatT;

    // Input side to lookahead FIR
    typedef struct packed {
        logic       valid;
        frameCodesT codes;
    } frameWordT;

    // Lookahead FIR to recursion
    typedef struct packed {
        logic   valid;
        firSumT sum;
    } firWordT;

    // Recursion to output side
    typedef struct packed {
        logic     valid;
        accValueT value;
    } accWordT;

    // Output side to sink, offset binary
    typedef struct packed {
        logic                    valid;
        logic [`DECIM_OUT_W-1:0] data;
    } resultWordT;

endpackage

/* hybridDecim.f */
+incdir+design
design/filterPkg.sv
design/streamPkg.sv
design/frameCollector.sv
design/lookaheadFir.sv
design/lookbackRecursion.sv
design/resultQueue.sv
design/hybridDecim.sv
tests/hybridDecimTb.sv

/* tests/hybridDecimTb.sv */
`timescale 1ns/1ps
`include "decim_cfg.svh"

module hybridDecimTb
    import streamPkg::*, filterPkg::*;
();

    localparam int sinkCredits = 2;
    localparam int randFrames = 200;
    localparam int constFrames = 60;
    localparam int gapFrames = 100;
    localparam int totalFrames = randFrames + constFrames + gapFrames;
    localparam int totalCodes = totalFrames * `DECIM_RATIO;
    localparam int watchdogCycles = totalFrames * `DECIM_RATIO * 20;
    localparam int settleCycles = 40;
    // Both halves of the triangle sum to R(R+1)/2
    localparam int coefTotal = `DECIM_RATIO * (`DECIM_RATIO + 1);

    logic       clkDS;
    logic       rstN;
    sampleBeatT inBeat;
    logic       inCredit;
    resultWordT outWord;
    logic       outCredit;

    // Credit bookkeeping for both ends of the chain
    int srcCount;
    int sinkCount;
    int sinkOwed;

    // Reference model state
    codeT       curFrame [`DECIM_RATIO];
    codeT       prevFrame [`DECIM_RATIO];
    int         frameFill;
    int         framesModelled;
    accValueT   modelAcc;
    resultWordT expectedQ [$];

    logic [15:0] lfsrState;
    int          codesSent;
    int          wordsReceived;

    hybridDecim #(
        .sinkCredits (sinkCredits)
    ) u_hybridDecim (
        .clkDS     (clkDS),
        .rstN      (rstN),
        .inBeat    (inBeat),
        .inCredit  (inCredit),
        .outWord   (outWord),
        .outCredit (outCredit)
    );

    initial begin
        clkDS = 1'b0;
        forever #2 clkDS = ~clkDS;
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[6:0], lfsrState[0]};
        end
    endtask

    task automatic failRun(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkResult(input resultWordT expWord, input resultWordT actWord);
        if (actWord !== expWord) begin
            failRun($sformatf("Error outWord expected 0x%h got 0x%h",
                expWord.data, actWord.data));
        end
    endtask

    task automatic checkCredit(input string name, input int count, input int limit);
        if (count < 0 || count > limit) begin
            failRun($sformatf("Error %s out of range 0x%h, limit 0x%h", name, count, limit));
        end
    endtask

    // FIR over previous and current frame, then leak, clamp and offset binary
    task automatic modelFrame();
        int                      firSum;
        int                      tapCode;
        int                      weight;
        int                      satVal;
        logic [`DECIM_OUT_W-1:0] data;
        resultWordT              expWord;
        if (framesModelled > 0) begin
            firSum = 0;
            for (int k = 0; k < `DECIM_TAPS; k++) begin
                if (k < `DECIM_RATIO) begin
                    tapCode = int'(curFrame[`DECIM_RATIO - 1 - k]);
                    weight = k + 1;
                end else begin
                    tapCode = int'(prevFrame[`DECIM_TAPS - 1 - k]);
                    weight = `DECIM_TAPS - k;
                end
                firSum += tapCode * weight;
            end
            modelAcc = modelAcc + accValueT'(firSum) - (modelAcc >>> `DECIM_LEAK_SHIFT);
            satVal = int'(modelAcc);
            if (satVal > 2 ** (`DECIM_OUT_W - 1) - 1) begin
                satVal = 2 ** (`DECIM_OUT_W - 1) - 1;
            end else if (satVal < -(2 ** (`DECIM_OUT_W - 1))) begin
                satVal = -(2 ** (`DECIM_OUT_W - 1));
            end
            data = satVal[`DECIM_OUT_W-1:0];
            data[`DECIM_OUT_W-1] = ~data[`DECIM_OUT_W-1];
            expWord.valid = 1'b1;
            expWord.data = data;
            expectedQ.push_back(expWord);
        end
        prevFrame = curFrame;
        framesModelled++;
    endtask

    task automatic driveSource();
        logic [7:0] bits;
        codeT       code;
        inBeat = '0;
        if (codesSent < totalCodes && srcCount > 0) begin
            drawBits(2, bits);
            // Idle about one cycle in four
            if (bits[1:0] != 2'b00) begin
                if (codesSent / `DECIM_RATIO >= randFrames
                    && codesSent / `DECIM_RATIO < randFrames + constFrames) begin
                    code = codeT'(1);
                end else begin
                    drawBits(2, bits);
                    code = codeT'(bits[1:0]);
                end
                inBeat.valid = 1'b1;
                inBeat.code = code;
                curFrame[frameFill] = code;
                frameFill++;
                codesSent++;
                if (frameFill == `DECIM_RATIO) begin
                    modelFrame();
                    frameFill = 0;
                end
            end
        end
    endtask

    task automatic driveSink();
        logic [7:0] bits;
        outCredit = 1'b0;
        if (sinkOwed > 0) begin
            if (codesSent < (randFrames + constFrames) * `DECIM_RATIO) begin
                outCredit = 1'b1;
            end else begin
                // Sparse credit returns to back-pressure the chain
                drawBits(3, bits);
                outCredit = (bits[2:0] == 3'b000);
            end
        end
    endtask

    task automatic sampleLinks();
        resultWordT                     expWord;
        logic signed [`DECIM_OUT_W-1:0] settled;
        if (inBeat.valid) begin
            srcCount--;
        end
        if (inCredit) begin
            srcCount++;
        end
        checkCredit("srcCount", srcCount, `DECIM_IN_CREDITS);
        if (outWord.valid) begin
            if (sinkCount == 0) begin
                failRun("outWord.valid was asserted while the sink had granted no credit");
            end else if (expectedQ.size() == 0) begin
                failRun("outWord carried a word that no completed frame accounts for");
            end else begin
                expWord = expectedQ.pop_front();
                checkResult(expWord, outWord);
                // Last word of the constant phase sits at the recursion's fixed point
                if (wordsReceived == randFrames + constFrames - 2) begin
                    settled = {~outWord.data[`DECIM_OUT_W-1], outWord.data[`DECIM_OUT_W-2:0]};
                    if ((int'(settled) >>> `DECIM_LEAK_SHIFT) != coefTotal) begin
                        failRun("constant codes did not settle at the recursion's fixed point");
                    end
                end
                sinkCount--;
                sinkOwed++;
                wordsReceived++;
            end
        end
        if (outCredit) begin
            sinkCount++;
            sinkOwed--;
        end
    endtask

    initial begin
        int doneCycles;
        lfsrState = 16'd56;
        rstN = 1'b0;
        inBeat = '0;
        outCredit = 1'b0;
        srcCount = `DECIM_IN_CREDITS;
        sinkCount = sinkCredits;
        sinkOwed = 0;
        frameFill = 0;
        framesModelled = 0;
        modelAcc = '0;
        codesSent = 0;
        wordsReceived = 0;
        doneCycles = 0;
        repeat (2) @(posedge clkDS);
        #1 rstN = 1'b1;
        while (doneCycles < settleCycles) begin
            @(posedge clkDS);
            #1;
            driveSource();
            driveSink();
            // Sample mid-cycle while inputs and outputs are stable
            @(negedge clkDS);
            sampleLinks();
            if (codesSent == totalCodes && wordsReceived == totalFrames - 1) begin
                doneCycles++;
            end
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clkDS);
        failRun($sformatf("Timeout: the run hung with %0d of %0d words received",
            wordsReceived, totalFrames - 1));
    end

endmodule
